// ==== hdl/memoryPkg.sv ====
/*
 * Memory bus types
 * Word address and data paths plus the request and response
 * structs shared by the loader, the checksum engine and the memory
 */
package memoryPkg;

    localparam int ADDR_WIDTH = 8;  // Word address, 256 words
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] AddrPath;
    typedef logic [DATA_WIDTH-1:0] DataPath;

    // Requester side, held until accepted
    typedef struct packed {
        AddrPath address;
        DataPath writeData;
        logic    readEnable;
        logic    writeEnable;
    } MemRequest;

    // Memory side
    typedef struct packed {
        DataPath readData;
        logic    readDataReady;  // One cycle, readData valid
        logic    busy;           // No new access accepted
    } MemResponse;

endpackage : memoryPkg

// ==== hdl/ioPkg.sv ====
/*
 * Board I/O types
 * Serial byte and LED paths
 */
package ioPkg;

    localparam int SERIAL_WIDTH = 8;
    localparam int LED_WIDTH = 8;

    typedef logic [SERIAL_WIDTH-1:0] SerialByte;

    // Bit 0 loaded, bit 1 sum sent, bits 7..2 low six sum bits
    typedef logic [LED_WIDTH-1:0] LedPath;

endpackage : ioPkg

// ==== hdl/resetController.sv ====
/*
 * Reset controller
 * Holds the system reset while the trigger is high or the clock
 * is not locked, stretches it, and flags the first cycle out of reset
 */
module resetController #(
    parameter int RESET_HOLD_CYCLES = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic locked,
    output logic rst,
    output logic rstStart
);

    localparam int COUNT_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);

    logic [COUNT_WIDTH-1:0] holdCount;
    logic rstDelayed;
    logic trigger;

    assign trigger = reset || !locked;

    always_ff @(posedge clk) begin
        if (trigger) begin
            holdCount <= COUNT_WIDTH'(RESET_HOLD_CYCLES);  // Reload while held
        end else if (holdCount != '0) begin
            holdCount <= holdCount - 1'b1;
        end
    end

    assign rst = trigger || (holdCount != '0);

    // Edge detect on the falling rst
    always_ff @(posedge clk) begin
        rstDelayed <= rst;
    end

    assign rstStart = rstDelayed && !rst;

endmodule : resetController

// ==== hdl/uartRx.sv ====
/*
 * UART receiver
 * Synchronizes rxd, samples each bit at its center and delivers
 * a byte with a one-cycle valid at the middle of the stop bit
 */
module uartRx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            rxd,
    output ioPkg::SerialByte rxByte,
    output logic            rxValid
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } RxState;

    RxState state;
    logic [1:0] syncReg;
    logic rxdSync;
    logic [CW-1:0] clkCount;
    logic [2:0] bitCount;
    ioPkg::SerialByte shiftReg;

    assign rxdSync = syncReg[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            syncReg <= 2'b11;  // Idle line is high
        end else begin
            syncReg <= {syncReg[0], rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RxIdle;
            clkCount <= '0;
            bitCount <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (state)
                RxIdle: begin
                    clkCount <= '0;
                    bitCount <= '0;
                    if (!rxdSync) state <= RxStart;
                end
                RxStart: begin  // Recheck the start bit at its center
                    if (clkCount == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clkCount <= '0;
                        state <= rxdSync ? RxIdle : RxData;
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                RxData: begin
                    if (clkCount == CW'(CLKS_PER_BIT - 1)) begin
                        clkCount <= '0;
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) state <= RxStop;
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                RxStop: begin
                    if (clkCount == CW'(CLKS_PER_BIT - 1)) begin
                        rxValid <= rxdSync;  // Framing error drops the byte
                        state <= RxIdle;
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                default: state <= RxIdle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RxData && clkCount == CW'(CLKS_PER_BIT - 1)) begin
            shiftReg <= {rxdSync, shiftReg[7:1]};
        end
        if (state == RxStop && clkCount == CW'(CLKS_PER_BIT - 1)) begin
            rxByte <= shiftReg;
        end
    end

endmodule : uartRx

// ==== hdl/uartTx.sv ====
/*
 * UART transmitter
 * Sends start bit, eight data bits LSB first and a stop bit on a
 * registered txd, ready again once the stop bit is out
 */
module uartTx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  ioPkg::SerialByte txByte,
    input  logic            txStart,
    output logic            txd,
    output logic            txReady
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic busy;
    logic [9:0] frame;  // Stop, data, start
    logic [CW-1:0] clkCount;
    logic [3:0] bitCount;

    assign txReady = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            txd <= 1'b1;
            clkCount <= '0;
            bitCount <= '0;
        end else if (!busy) begin
            txd <= 1'b1;
            if (txStart) begin
                busy <= 1'b1;
                frame <= {1'b1, txByte, 1'b0};
                clkCount <= '0;
                bitCount <= '0;
            end
        end else begin
            txd <= frame[0];
            if (clkCount == CW'(CLKS_PER_BIT - 1)) begin
                clkCount <= '0;
                frame <= {1'b1, frame[9:1]};
                if (bitCount == 4'd9) begin
                    busy <= 1'b0;  // Stop bit done
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end else begin
                clkCount <= clkCount + 1'b1;
            end
        end
    end

endmodule : uartTx

// ==== hdl/programLoader.sv ====
/*
 * Program loader
 * Packs received bytes into little-endian words, writes them to
 * memory from address 0 and owns the bus until the image is in
 */
module programLoader #(
    parameter int IMAGE_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ioPkg::SerialByte     rxByte,
    input  logic                 rxValid,
    input  memoryPkg::MemRequest  coreRequest,
    input  memoryPkg::MemResponse memResponse,
    output memoryPkg::MemRequest  memRequest,
    output logic                 programLoaded
);

    logic [1:0] byteIndex;
    memoryPkg::AddrPath wordCount;
    memoryPkg::DataPath wordData;
    logic writeEnable;

    always_ff @(posedge clk) begin
        if (rst) begin
            byteIndex <= '0;
            wordCount <= '0;
            writeEnable <= 1'b0;
            programLoaded <= 1'b0;
        end else begin
            if (rxValid && !programLoaded) begin
                byteIndex <= byteIndex + 1'b1;
                if (byteIndex == 2'd3) writeEnable <= 1'b1;  // Word complete
            end
            if (writeEnable && !memResponse.busy) begin
                writeEnable <= 1'b0;
                if (wordCount == memoryPkg::AddrPath'(IMAGE_WORDS - 1)) begin
                    programLoaded <= 1'b1;
                end else begin
                    wordCount <= wordCount + 1'b1;
                end
            end
        end
    end

    // First byte ends up in the low lane
    always_ff @(posedge clk) begin
        if (rxValid && !programLoaded) begin
            wordData <= {rxByte, wordData[memoryPkg::DATA_WIDTH-1:8]};
        end
    end

    // Bus mux, no reads while loading
    always_comb begin
        if (!programLoaded) begin
            memRequest.address = wordCount;
            memRequest.writeData = wordData;
            memRequest.readEnable = 1'b0;
            memRequest.writeEnable = writeEnable;
        end else begin
            memRequest = coreRequest;
        end
    end

endmodule : programLoader

// ==== hdl/memory.sv ====
/*
 * Internal word memory
 * Two-cycle read latency with a one-cycle ready pulse, writes in
 * one cycle, busy while an access is in flight
 */
module memory (
    input  logic                 clk,
    input  logic                 rst,
    input  memoryPkg::MemRequest  memRequest,
    output memoryPkg::MemResponse memResponse
);

    localparam int DEPTH = 2 ** memoryPkg::ADDR_WIDTH;

    memoryPkg::DataPath storage [DEPTH];
    memoryPkg::DataPath readStage1Data;
    memoryPkg::DataPath readStage2Data;
    logic readStage1;
    logic readStage2;
    logic writeStage;
    logic accept;
    logic readAccept;
    logic writeAccept;

    assign accept = (memRequest.readEnable || memRequest.writeEnable) && !memResponse.busy;
    assign writeAccept = accept && memRequest.writeEnable;  // Write wins a tie
    assign readAccept = accept && memRequest.readEnable && !memRequest.writeEnable;

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            storage[memRequest.address] <= memRequest.writeData;
        end
        if (readAccept) begin
            readStage1Data <= storage[memRequest.address];
        end
        readStage2Data <= readStage1Data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readStage1 <= 1'b0;
            readStage2 <= 1'b0;
            writeStage <= 1'b0;
        end else begin
            readStage1 <= readAccept;
            readStage2 <= readStage1;
            writeStage <= writeAccept;
        end
    end

    assign memResponse.readData = readStage2Data;
    assign memResponse.readDataReady = readStage2;
    assign memResponse.busy = readStage1 || readStage2 || writeStage;

endmodule : memory

// ==== hdl/checksumCore.sv ====
/*
 * Checksum engine
 * Waits for the loaded image, reads and sums every word, sends
 * the 32-bit sum over the UART and shows status on the LEDs
 */
module checksumCore #(
    parameter int IMAGE_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rstStart,
    input  logic                 programLoaded,
    input  memoryPkg::MemResponse memResponse,
    output memoryPkg::MemRequest  coreRequest,
    output ioPkg::SerialByte     txByte,
    output logic                 txStart,
    input  logic                 txReady,
    output ioPkg::LedPath        ledOut
);

    typedef enum logic [2:0] {
        CoreWait,
        CoreRead,
        CoreAccum,
        CoreSend,
        CoreDone
    } CoreState;

    CoreState state;
    memoryPkg::AddrPath readAddress;
    memoryPkg::DataPath sum;
    logic [1:0] byteIndex;

    // Read-only requester
    assign coreRequest.address = readAddress;
    assign coreRequest.writeData = '0;
    assign coreRequest.readEnable = (state == CoreRead);
    assign coreRequest.writeEnable = 1'b0;

    assign txByte = sum[{byteIndex, 3'b000} +: 8];
    assign txStart = (state == CoreSend) && txReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CoreWait;
            readAddress <= '0;
            sum <= '0;
            byteIndex <= '0;
        end else begin
            case (state)
                CoreWait: begin
                    readAddress <= '0;
                    sum <= '0;
                    byteIndex <= '0;
                    if (programLoaded) state <= CoreRead;
                end
                CoreRead: begin
                    if (!memResponse.busy) state <= CoreAccum;  // Accepted
                end
                CoreAccum: begin
                    if (memResponse.readDataReady) begin
                        sum <= sum + memResponse.readData;
                        if (readAddress == memoryPkg::AddrPath'(IMAGE_WORDS - 1)) begin
                            state <= CoreSend;
                        end else begin
                            readAddress <= readAddress + 1'b1;
                            state <= CoreRead;
                        end
                    end
                end
                CoreSend: begin
                    if (txReady) begin
                        byteIndex <= byteIndex + 1'b1;
                        if (byteIndex == 2'd3) state <= CoreDone;
                    end
                end
                CoreDone: state <= CoreDone;  // Hold until reset
                default: state <= CoreWait;
            endcase
        end
    end

    // Status LEDs
    always_ff @(posedge clk) begin
        if (rst || rstStart) begin
            ledOut <= '0;
        end else begin
            ledOut[0] <= programLoaded;
            ledOut[1] <= (state == CoreDone);
            ledOut[7:2] <= (state == CoreDone) ? sum[5:0] : 6'b0;
        end
    end

endmodule : checksumCore

// ==== hdl/boardTop.sv ====
/*
 * Board top level
 * Reset control, UART loader, internal memory, checksum engine
 * and UART transmitter
 */
module boardTop #(
    parameter int CLKS_PER_BIT = 8,
    parameter int IMAGE_WORDS = 16,
    parameter int RESET_HOLD_CYCLES = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          locked,
    input  logic          rxd,
    output logic          txd,
    output ioPkg::LedPath ledOut,
    output logic          resetOut
);

    logic rst;
    logic rstStart;
    logic programLoaded;
    ioPkg::SerialByte rxByte;
    logic rxValid;
    ioPkg::SerialByte txByte;
    logic txStart;
    logic txReady;
    memoryPkg::MemRequest coreRequest;
    memoryPkg::MemRequest memRequest;
    memoryPkg::MemResponse memResponse;

    assign resetOut = rst;

    resetController #(.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)) u_resetController (
        .clk(clk), .reset(reset), .locked(locked), .rst(rst), .rstStart(rstStart)
    );

    uartRx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uartRx (
        .clk(clk), .rst(rst), .rxd(rxd), .rxByte(rxByte), .rxValid(rxValid)
    );

    programLoader #(.IMAGE_WORDS(IMAGE_WORDS)) u_programLoader (
        .clk(clk), .rst(rst), .rxByte(rxByte), .rxValid(rxValid),
        .coreRequest(coreRequest), .memResponse(memResponse),
        .memRequest(memRequest), .programLoaded(programLoaded)
    );

    memory u_memory (
        .clk(clk), .rst(rst), .memRequest(memRequest), .memResponse(memResponse)
    );

    // Stays in its wait state until the image is loaded
    checksumCore #(.IMAGE_WORDS(IMAGE_WORDS)) u_checksumCore (
        .clk(clk), .rst(rst), .rstStart(rstStart), .programLoaded(programLoaded),
        .memResponse(memResponse), .coreRequest(coreRequest),
        .txByte(txByte), .txStart(txStart), .txReady(txReady), .ledOut(ledOut)
    );

    uartTx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uartTx (
        .clk(clk), .rst(rst), .txByte(txByte), .txStart(txStart),
        .txd(txd), .txReady(txReady)
    );

endmodule : boardTop

// ==== tb/boardTopTb.sv ====
/*
 * Testbench for boardTop
 * Uploads random images over rxd, decodes the checksum frames on
 * txd and checks reset, loading, LED status and restart behavior
 */
module boardTopTb;

    localparam int CLKS_PER_BIT = 8;
    localparam int IMAGE_WORDS = 16;
    localparam int RESET_HOLD_CYCLES = 4;
    localparam int CLK_PERIOD = 4;
    localparam int SEED = 16;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int IMAGE_BYTES = 4 * IMAGE_WORDS;
    localparam int PARTIAL_BYTES = 6;  // Sent before the restart reset
    localparam int UPLOAD_FRAMES = 2 * IMAGE_BYTES + PARTIAL_BYTES;
    localparam int TX_FRAMES = 8;
    localparam int WATCHDOG_TIME =
        2 * (UPLOAD_FRAMES + TX_FRAMES) * FRAME_CYCLES * CLK_PERIOD + 4000;

    logic clk;
    logic reset;
    logic locked;
    logic rxd;
    logic txd;
    ioPkg::LedPath ledOut;
    logic resetOut;

    logic [31:0] imageWords [IMAGE_WORDS];
    logic [7:0] txBytes [$];  // Decoded txd frames

    boardTop #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .IMAGE_WORDS(IMAGE_WORDS),
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_dut (
        .clk(clk), .reset(reset), .locked(locked), .rxd(rxd),
        .txd(txd), .ledOut(ledOut), .resetOut(resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic endWithFailure();
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
        endWithFailure();
    endtask

    task automatic reportFailure(input string what);
        $display("[ERROR] %s", what);
        endWithFailure();
    endtask

    // Registered outputs settle one cycle into reset and hold through the first free cycle
    resetHoldsOutputs: assert property (@(posedge clk) resetOut |=> (txd && ledOut == '0))
        else reportMismatch("resetState", 32'h100, {$sampled(txd), $sampled(ledOut)});

    initial begin
        #(WATCHDOG_TIME);
        reportFailure("watchdog expired before the tests finished");
    end

    // One 8N1 frame entered and left one unit after a rising edge
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [31:0] makeImage();
        logic [31:0] expectedSum;
        expectedSum = '0;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            imageWords[i] = $urandom;
            expectedSum = expectedSum + imageWords[i];  // Wraps modulo 2^32
        end
        return expectedSum;
    endfunction

    // Little-endian bytes of the current image
    task automatic uploadBytes(input int count, input bit checkLoading);
        logic [7:0] value;
        @(posedge clk);
        #1;
        for (int k = 0; k < count; k++) begin
            value = imageWords[k / 4][8 * (k % 4) +: 8];
            if (checkLoading) begin
                assert (!ledOut[0]) else reportMismatch("loadingLed", 32'h0, 32'(ledOut[0]));
            end
            sendByte(value);
        end
    endtask

    task automatic waitLoaded();
        int cycles;
        cycles = 0;
        while (!ledOut[0] && cycles < FRAME_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (ledOut[0])
            else reportFailure("LED bit 0 did not rise within a frame of the last byte");
    endtask

    task automatic checkChecksum(input string phase, input logic [31:0] sum);
        int cycles;
        cycles = 0;
        while (txBytes.size() < 4 && cycles < 8 * FRAME_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (txBytes.size() >= 4)
            else reportFailure({phase, ": fewer than four frames on txd"});
        repeat (CLKS_PER_BIT) @(posedge clk);  // Rest of the last stop bit
        #1;
        assert (ledOut[1]) else reportMismatch({phase, " sentLed"}, 32'h1, 32'(ledOut[1]));
        assert (ledOut[7:2] == sum[5:0])
            else reportMismatch({phase, " sumLeds"}, 32'(sum[5:0]), 32'(ledOut[7:2]));
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        #1;
        assert (txBytes.size() == 4)
            else reportMismatch({phase, " frameCount"}, 32'd4, 32'(txBytes.size()));
        for (int i = 0; i < 4; i++) begin
            assert (txBytes[i] == sum[8 * i +: 8])
                else reportMismatch($sformatf("%s checksumByte%0d", phase, i),
                                    32'(sum[8 * i +: 8]), 32'(txBytes[i]));
        end
    endtask

    task automatic runImage(input string phase);
        logic [31:0] expectedSum;
        expectedSum = makeImage();
        uploadBytes(IMAGE_BYTES, 1'b1);
        waitLoaded();
        checkChecksum(phase, expectedSum);
    endtask

    // txd decoder sampling mid-cycle on the falling edge
    initial begin
        logic [7:0] frameByte;
        forever begin
            @(negedge clk);
            if (txd === 1'b0) begin
                assert (ledOut[0])
                    else reportFailure("start bit on txd before the image was loaded");
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    frameByte[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (txd === 1'b1) else reportMismatch("stopBit", 32'h1, 32'(txd));
                txBytes.push_back(frameByte);
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(SEED));
        reset = 1'b1;
        locked = 1'b0;
        rxd = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        // Reset stretch against the clock lock
        repeat (10) begin
            @(posedge clk);
            #1;
            assert (resetOut) else reportMismatch("resetWhileUnlocked", 32'h1, 32'(resetOut));
        end
        locked = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (resetOut && cycles < 50);
        assert (cycles == RESET_HOLD_CYCLES)
            else reportMismatch("resetRelease", 32'(RESET_HOLD_CYCLES), 32'(cycles));

        runImage("firstImage");
        txBytes.delete();

        // Restart in the middle of a second upload
        void'(makeImage());
        uploadBytes(PARTIAL_BYTES, 1'b0);
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        assert (!ledOut[0]) else reportMismatch("restartLed", 32'h0, 32'(ledOut[0]));
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (resetOut && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (!resetOut) else reportFailure("resetOut stayed high after the restart");
        assert (txBytes.size() == 0)
            else reportMismatch("restartQuiet", 32'h0, 32'(txBytes.size()));
        runImage("restartImage");

        $display("=== PASS ===");
        $finish;
    end

endmodule : boardTopTb

// ==== files.f ====
hdl/memoryPkg.sv
hdl/ioPkg.sv
hdl/resetController.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/programLoader.sv
hdl/memory.sv
hdl/checksumCore.sv
hdl/boardTop.sv
tb/boardTopTb.sv

// ==== Makefile ====
# Verilator flow for boardTop and its testbench

TB_TOP := boardTopTb
LOG    := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TB_TOP)
	verilator --lint-only -Wall hdl/memoryPkg.sv hdl/ioPkg.sv hdl/resetController.sv \
		hdl/uartRx.sv hdl/uartTx.sv hdl/programLoader.sv hdl/memory.sv \
		hdl/checksumCore.sv hdl/boardTop.sv --top-module boardTop

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
